//--- verilog.f
design/volley_pkg.sv
design/player_motion.sv
design/ball_dynamics.sv
design/volley_physics.sv
sim/tb_clock.sv
sim/tb_checker.sv
sim/tb_top.sv

//--- Makefile
TOP := tb_top

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
		--top-module $(TOP) -f verilog.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- sim/tb_top.sv
`default_nettype none

module tb_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int IDLE_FRAMES    = 20;
    localparam int MOTION_FRAMES  = 400;
    localparam int FLIGHT_RALLIES = 6;
    localparam int FLIGHT_FRAMES  = 60;
    localparam int HIT_RALLIES    = 8;
    localparam int HIT_FRAMES     = 80;
    localparam int GROUND_RALLIES = 6;
    localparam int LAND_LIMIT     = 300;
    localparam int TOTAL_FRAMES   = 2 + IDLE_FRAMES + MOTION_FRAMES
                                  + FLIGHT_RALLIES * (2 + FLIGHT_FRAMES)
                                  + HIT_RALLIES * (2 + HIT_FRAMES)
                                  + GROUND_RALLIES * (LAND_LIMIT + 5) + 3;

    logic                      fps30;
    logic                      rst;
    logic                      play;
    logic                      serve_a;
    volley_pkg::player_keys_t  keys_a;
    volley_pkg::player_keys_t  keys_b;
    volley_pkg::player_state_t player_a;
    volley_pkg::player_state_t player_b;
    volley_pkg::ball_state_t   ball;
    logic [1:0]                touch_ground;
    int                        error_total;

    logic [31:0]               lcg_state;
    int                        run_a;
    int                        run_b;
    logic                      landed;

    tb_clock clock0 (
        .fps30 (fps30),
        .rst   (rst)
    );

    volley_physics dut0 (
        .fps30        (fps30),
        .rst          (rst),
        .play         (play),
        .serve_a      (serve_a),
        .keys_a       (keys_a),
        .keys_b       (keys_b),
        .player_a     (player_a),
        .player_b     (player_b),
        .ball         (ball),
        .touch_ground (touch_ground)
    );

    tb_checker chk0 (
        .fps30        (fps30),
        .rst          (rst),
        .play         (play),
        .serve_a      (serve_a),
        .keys_a       (keys_a),
        .keys_b       (keys_b),
        .player_a     (player_a),
        .player_b     (player_b),
        .ball         (ball),
        .touch_ground (touch_ground),
        .error_total  (error_total)
    );

    function automatic int unsigned lcg_draw(int unsigned n);
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return (lcg_state >> 8) % n;    // low bits are weak
    endfunction

    // steering walks toward the ball
    function automatic volley_pkg::player_keys_t pick_keys(logic steer,
                                                           volley_pkg::coord_t x);
        volley_pkg::player_keys_t k;
        k.jump = (lcg_draw(4) == 0);
        if (steer) begin
            k.left  = (ball.x < x - 11'sd10);
            k.right = (ball.x > x + 11'sd10);
        end else begin
            k.left  = (lcg_draw(2) == 1);
            k.right = (lcg_draw(2) == 1);
        end
        return k;
    endfunction

    task automatic update_keys(input logic steer);
        if (run_a == 0) begin
            keys_a <= pick_keys(steer, player_a.x);
            run_a  = lcg_draw(steer ? 4 : 20);    // held 1 to 20 frames
        end else begin
            run_a--;
        end
        if (run_b == 0) begin
            keys_b <= pick_keys(steer, player_b.x);
            run_b  = lcg_draw(steer ? 4 : 20);
        end else begin
            run_b--;
        end
    endtask

    task automatic serve_pause(input int frames);
        @(posedge fps30);
        play    <= 1'b0;
        keys_a  <= '0;
        keys_b  <= '0;
        serve_a <= (lcg_draw(2) == 1);
        run_a   = 0;
        run_b   = 0;
        repeat (frames - 1) @(posedge fps30);
    endtask

    // mode 0 no keys, 1 random keys, 2 mostly steered
    task automatic rally(input int frames, input int mode);
        for (int i = 0; i < frames; i++) begin
            @(posedge fps30);
            play <= 1'b1;
            if (mode == 1) begin
                update_keys(1'b0);
            end else if (mode == 2) begin
                update_keys(lcg_draw(4) != 0);
            end
        end
    endtask

    task automatic finish_phase();
        @(negedge fps30);
        #1;
        chk0.end_test();
    endtask

    initial begin
        play      = 1'b0;
        serve_a   = 1'b0;
        keys_a    = '0;
        keys_b    = '0;
        lcg_state = 32'h85f53069;
        run_a     = 0;
        run_b     = 0;
        landed    = 1'b0;

        chk0.begin_test("reset_idle");
        wait (rst == 1'b0);
        for (int i = 0; i < IDLE_FRAMES; i++) begin
            @(posedge fps30);
            if (i % 3 == 0) begin
                serve_a <= ~serve_a;
            end
        end
        finish_phase();

        chk0.begin_test("player_motion");
        rally(MOTION_FRAMES, 1);
        finish_phase();

        chk0.begin_test("ball_flight");
        for (int r = 0; r < FLIGHT_RALLIES; r++) begin
            serve_pause(2);
            rally(FLIGHT_FRAMES, 0);
        end
        finish_phase();

        chk0.begin_test("player_hits");
        for (int r = 0; r < HIT_RALLIES; r++) begin
            serve_pause(2);
            rally(HIT_FRAMES, 2);
        end
        finish_phase();

        chk0.begin_test("ground_serve");
        for (int r = 0; r < GROUND_RALLIES; r++) begin
            serve_pause(3);
            landed = 1'b0;
            for (int n = 0; n < LAND_LIMIT && !landed; n++) begin
                @(posedge fps30);
                play   <= 1'b1;
                landed = (touch_ground != volley_pkg::GROUND_NONE);
            end
            if (!landed) begin
                chk0.note_failure("the ball never touched the ground within the frame limit");
            end
            repeat (2) @(posedge fps30);
        end
        serve_pause(3);
        finish_phase();

        chk0.print_summary();
        if (error_total == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(TOTAL_FRAMES * 12);    // 1.5 frames of 8 ns each
        $display("watchdog: stimulus did not finish within %0d ns", TOTAL_FRAMES * 12);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim/tb_checker.sv
`default_nettype none

module tb_checker (
    input  wire logic                      fps30,
    input  wire logic                      rst,
    input  wire logic                      play,
    input  wire logic                      serve_a,
    input  wire volley_pkg::player_keys_t  keys_a,
    input  wire volley_pkg::player_keys_t  keys_b,
    input  wire volley_pkg::player_state_t player_a,
    input  wire volley_pkg::player_state_t player_b,
    input  wire volley_pkg::ball_state_t   ball,
    input  wire logic [1:0]                touch_ground,
    output int                             error_total
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SHOW_LIMIT = 20;

    // reference state, index 0 is player a
    int         px [2];
    int         py [2];
    int         pvx [2];
    int         pvy [2];
    int         bx;
    int         by;
    int         bvx;
    int         bvy;
    logic [1:0] ground;

    string      test_name = "none";
    int         test_frames = 0;
    int         test_errors = 0;
    int         tests_run = 0;
    int         tests_failed = 0;
    int         errors_all = 0;

    assign error_total = errors_all;

    function automatic int clamp(int v, int lo, int hi);
        if (v < lo) begin
            return lo;
        end
        if (v > hi) begin
            return hi;
        end
        return v;
    endfunction

    function automatic bit near(int qx, int qy);
        return (bx - qx <= 30) && (qx - bx <= 30) && (by - qy <= 40) && (qy - by <= 40);
    endfunction

    task automatic reset_model(input int serve_x);
        px[0]  = volley_pkg::A_START_X;
        px[1]  = volley_pkg::B_START_X;
        for (int i = 0; i < 2; i++) begin
            py[i]  = volley_pkg::START_Y;
            pvx[i] = 0;
            pvy[i] = 0;
        end
        bx     = serve_x;
        by     = volley_pkg::SERVE_Y;
        bvx    = 0;
        bvy    = 0;
        ground = volley_pkg::GROUND_NONE;
    endtask

    task automatic step_player(input int i, input volley_pkg::player_keys_t k,
                               input int x_min, input int x_max);
        int old_x;
        int old_y;
        old_x = px[i];
        old_y = py[i];
        px[i] = clamp(old_x + pvx[i], x_min, x_max);    // old velocity moves it
        py[i] = clamp(old_y + pvy[i], 50, 390);
        if (k.left && !k.right && old_x > x_min) begin
            pvx[i] = -4;
        end else if (k.right && !k.left && old_x < x_max) begin
            pvx[i] = 4;
        end else begin
            pvx[i] = 0;
        end
        if (k.jump && old_y == 390) begin
            pvy[i] = -30;
        end else if (old_y == 390) begin
            pvy[i] = 0;
        end else if (pvy[i] < 30) begin
            pvy[i] = pvy[i] + 2;
        end
    endtask

    task automatic step_ball();
        int  nx;
        int  ny;
        int  cx;
        bit  side_hit;
        nx       = bx + bvx / 10;    // int division truncates toward zero
        ny       = by + bvy / 10;
        cx       = clamp(nx, 38, 592);
        side_hit = (nx <= 38) || (nx >= 592);
        if (bx <= 285 && nx >= 285 && by >= 270) begin
            cx       = 285;
            side_hit = 1'b1;
        end else if (bx >= 335 && nx <= 335 && by >= 270) begin
            cx       = 335;
            side_hit = 1'b1;
        end
        if (by != 400) begin
            ground = 2'd0;
        end else begin
            ground = (bx < 320) ? 2'd1 : 2'd2;
        end
        if (by == 400) begin
            bvx = 0;
            bvy = 0;
        end else if (near(px[0], py[0])) begin
            bvx = 50;
            bvy = -100;
        end else if (near(px[1], py[1])) begin
            bvx = -50;
            bvy = -100;
        end else begin
            if (side_hit) begin
                bvx = -bvx;
            end else if (bvx > 40) begin
                bvx = bvx - 2;
            end else if (bvx < -40) begin
                bvx = bvx + 2;
            end
            if (ny <= 38) begin
                bvy = -bvy;    // ceiling bounce
            end else if (bvy < 150) begin
                bvy = bvy + 5;
            end
        end
        bx = cx;
        by = clamp(ny, 38, 400);
    endtask

    task automatic count_error();
        test_errors++;
        errors_all++;
        if (test_errors == SHOW_LIMIT + 1) begin
            $display("%s: further mismatches not shown", test_name);
        end
    endtask

    task automatic compare_xy(input string label, input int ex, input int ey,
                              input volley_pkg::coord_t ax, input volley_pkg::coord_t ay);
        if (ax !== volley_pkg::coord_t'(ex) || ay !== volley_pkg::coord_t'(ey)) begin
            if (test_errors < SHOW_LIMIT) begin
                $display("[FAIL] %s %s expected (%0d,%0d) actual (%0d,%0d)",
                         test_name, label, ex, ey, ax, ay);
            end
            count_error();
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_frames = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %-14s %5d frames %4d errors  %s", test_name, test_frames,
                 test_errors, (test_errors == 0) ? "ok" : "failed");
    endtask

    task automatic note_failure(input string what);
        $display("%s: %s", test_name, what);
        test_errors++;
        errors_all++;
    endtask

    task automatic print_summary();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors_all);
    endtask

    initial begin
        reset_model(volley_pkg::SERVE_B_X);
    end

    always @(posedge fps30) begin
        if (rst) begin
            reset_model(volley_pkg::SERVE_B_X);
        end else if (!play) begin
            reset_model(serve_a ? volley_pkg::SERVE_A_X : volley_pkg::SERVE_B_X);
        end else begin
            step_ball();    // sees the players before they move
            step_player(0, keys_a, volley_pkg::A_X_MIN, volley_pkg::A_X_MAX);
            step_player(1, keys_b, volley_pkg::B_X_MIN, volley_pkg::B_X_MAX);
        end
    end

    // outputs are settled half a frame after the edge
    always @(negedge fps30) begin
        test_frames++;
        compare_xy("player_a", px[0], py[0], player_a.x, player_a.y);
        compare_xy("player_b", px[1], py[1], player_b.x, player_b.y);
        compare_xy("ball", bx, by, ball.x, ball.y);
        if (touch_ground !== ground) begin
            if (test_errors < SHOW_LIMIT) begin
                $display("[FAIL] %s touch_ground expected %0d actual %0d",
                         test_name, ground, touch_ground);
            end
            count_error();
        end
    end

endmodule

`default_nettype wire

//--- sim/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic fps30,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        fps30 = 1'b0;
        forever #4 fps30 = ~fps30;    // 8 ns frame
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge fps30);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- design/volley_physics.sv
`default_nettype none

module volley_physics (
    input  wire logic                       fps30,
    input  wire logic                       rst,
    input  wire logic                       play,
    input  wire logic                       serve_a,
    input  wire volley_pkg::player_keys_t   keys_a,
    input  wire volley_pkg::player_keys_t   keys_b,
    output wire volley_pkg::player_state_t  player_a,
    output wire volley_pkg::player_state_t  player_b,
    output wire volley_pkg::ball_state_t    ball,
    output wire logic [1:0]                 touch_ground
);

    player_motion #(
        .x_min   (volley_pkg::A_X_MIN),
        .x_max   (volley_pkg::A_X_MAX),
        .start_x (volley_pkg::A_START_X)
    ) player_a0 (
        .fps30 (fps30),
        .rst   (rst),
        .play  (play),
        .keys  (keys_a),
        .state (player_a)
    );

    player_motion #(
        .x_min   (volley_pkg::B_X_MIN),
        .x_max   (volley_pkg::B_X_MAX),
        .start_x (volley_pkg::B_START_X)
    ) player_b0 (
        .fps30 (fps30),
        .rst   (rst),
        .play  (play),
        .keys  (keys_b),
        .state (player_b)
    );

    // ball sees both players as held before the edge
    ball_dynamics ball0 (
        .fps30        (fps30),
        .rst          (rst),
        .play         (play),
        .serve_a      (serve_a),
        .player_a     (player_a),
        .player_b     (player_b),
        .ball         (ball),
        .touch_ground (touch_ground)
    );

endmodule

`default_nettype wire

//--- design/ball_dynamics.sv
`default_nettype none

module ball_dynamics (
    input  wire logic                      fps30,
    input  wire logic                      rst,
    input  wire logic                      play,
    input  wire logic                      serve_a,
    input  wire volley_pkg::player_state_t player_a,
    input  wire volley_pkg::player_state_t player_b,
    output volley_pkg::ball_state_t        ball,
    output logic [1:0]                     touch_ground
);

    volley_pkg::vel_t   vx;
    volley_pkg::vel_t   vy;
    volley_pkg::vel_t   next_vx;
    volley_pkg::vel_t   next_vy;
    volley_pkg::vel_t   dx;
    volley_pkg::vel_t   dy;

    logic signed [11:0] nx_raw;
    logic signed [11:0] ny_raw;
    volley_pkg::coord_t nx;
    volley_pkg::coord_t ny;

    logic               wall_hit;
    logic               net_hit;
    logic               ceil_hit;
    logic               landed;
    logic               hit_a;
    logic               hit_b;
    logic [1:0]         next_ground;
    volley_pkg::coord_t serve_x;

    // box test between the ball and one player
    function automatic logic in_range(volley_pkg::ball_state_t b,
                                      volley_pkg::player_state_t p);
        logic signed [11:0] diff_x;
        logic signed [11:0] diff_y;
        diff_x = b.x - p.x;
        diff_y = b.y - p.y;
        return diff_x <= volley_pkg::HIT_RANGE_X && diff_x >= -volley_pkg::HIT_RANGE_X &&
               diff_y <= volley_pkg::HIT_RANGE_Y && diff_y >= -volley_pkg::HIT_RANGE_Y;
    endfunction

    assign dx = vx / 10'sd10;               // truncates toward zero
    assign dy = vy / 10'sd10;
    assign nx_raw = ball.x + dx;
    assign ny_raw = ball.y + dy;

    assign landed  = (ball.y == volley_pkg::BALL_Y_MAX);
    assign hit_a   = in_range(ball, player_a);
    assign hit_b   = in_range(ball, player_b);
    assign serve_x = serve_a ? volley_pkg::SERVE_A_X : volley_pkg::SERVE_B_X;

    // horizontal step with walls, then the net faces
    always_comb begin
        wall_hit = 1'b0;
        net_hit  = 1'b0;
        if (nx_raw <= volley_pkg::BALL_X_MIN) begin
            nx       = volley_pkg::BALL_X_MIN;
            wall_hit = 1'b1;
        end else if (nx_raw >= volley_pkg::BALL_X_MAX) begin
            nx       = volley_pkg::BALL_X_MAX;
            wall_hit = 1'b1;
        end else begin
            nx = volley_pkg::coord_t'(nx_raw);
        end

        if (ball.x <= volley_pkg::NET_LEFT && nx_raw >= volley_pkg::NET_LEFT &&
            ball.y >= volley_pkg::NET_TOP) begin
            nx      = volley_pkg::NET_LEFT;    // from the a side
            net_hit = 1'b1;
        end else if (ball.x >= volley_pkg::NET_RIGHT && nx_raw <= volley_pkg::NET_RIGHT &&
                     ball.y >= volley_pkg::NET_TOP) begin
            nx      = volley_pkg::NET_RIGHT;   // from the b side
            net_hit = 1'b1;
        end
    end

    // vertical step with ceiling and ground
    always_comb begin
        ceil_hit = 1'b0;
        if (ny_raw <= volley_pkg::BALL_Y_MIN) begin
            ny       = volley_pkg::BALL_Y_MIN;
            ceil_hit = 1'b1;
        end else if (ny_raw >= volley_pkg::BALL_Y_MAX) begin
            ny = volley_pkg::BALL_Y_MAX;
        end else begin
            ny = volley_pkg::coord_t'(ny_raw);
        end
    end

    // a hit beats the bounces; player a wins a tie
    always_comb begin
        if (landed) begin
            next_vx = '0;
            next_vy = '0;
        end else if (hit_a) begin
            next_vx = volley_pkg::HIT_VX;
            next_vy = -volley_pkg::HIT_VY;
        end else if (hit_b) begin
            next_vx = -volley_pkg::HIT_VX;
            next_vy = -volley_pkg::HIT_VY;
        end else begin
            if (wall_hit || net_hit) begin
                next_vx = -vx;
            end else if (vx > volley_pkg::DRAG_LIMIT) begin
                next_vx = vx - volley_pkg::DRAG;
            end else if (vx < -volley_pkg::DRAG_LIMIT) begin
                next_vx = vx + volley_pkg::DRAG;
            end else begin
                next_vx = vx;
            end

            if (ceil_hit) begin
                next_vy = -vy;
            end else if (vy < volley_pkg::BALL_MAX_FALL) begin
                next_vy = vy + volley_pkg::BALL_GRAVITY;
            end else begin
                next_vy = vy;
            end
        end
    end

    // landing side from the pre-edge position
    always_comb begin
        if (!landed) begin
            next_ground = volley_pkg::GROUND_NONE;
        end else if (ball.x < volley_pkg::MIDCOURT) begin
            next_ground = volley_pkg::GROUND_LEFT;
        end else begin
            next_ground = volley_pkg::GROUND_RIGHT;
        end
    end

    always_ff @(posedge fps30 or posedge rst) begin
        if (rst) begin
            ball.x       <= volley_pkg::SERVE_B_X;
            ball.y       <= volley_pkg::SERVE_Y;
            vx           <= '0;
            vy           <= '0;
            touch_ground <= volley_pkg::GROUND_NONE;
        end else if (!play) begin
            ball.x       <= serve_x;         // winner serves next
            ball.y       <= volley_pkg::SERVE_Y;
            vx           <= '0;
            vy           <= '0;
            touch_ground <= volley_pkg::GROUND_NONE;
        end else begin
            ball.x       <= nx;
            ball.y       <= ny;
            vx           <= next_vx;
            vy           <= next_vy;
            touch_ground <= next_ground;
        end
    end

    ground_after_landing: assert property (
        @(posedge fps30) disable iff (rst)
        touch_ground != volley_pkg::GROUND_NONE |-> $past(ball.y) == volley_pkg::BALL_Y_MAX
    );

endmodule

`default_nettype wire

//--- design/player_motion.sv
`default_nettype none

module player_motion #(
    parameter volley_pkg::coord_t x_min   = volley_pkg::A_X_MIN,
    parameter volley_pkg::coord_t x_max   = volley_pkg::A_X_MAX,
    parameter volley_pkg::coord_t start_x = volley_pkg::A_START_X
) (
    input  wire logic                     fps30,
    input  wire logic                     rst,
    input  wire logic                     play,
    input  wire volley_pkg::player_keys_t keys,
    output volley_pkg::player_state_t     state
);

    volley_pkg::vel_t   vx;
    volley_pkg::vel_t   vy;
    volley_pkg::vel_t   next_vx;
    volley_pkg::vel_t   next_vy;

    logic signed [11:0] sum_x;              // one bit of headroom
    logic signed [11:0] sum_y;
    volley_pkg::coord_t next_x;
    volley_pkg::coord_t next_y;

    logic               only_left;
    logic               only_right;
    logic               on_ground;

    assign only_left  = keys.left && !keys.right;
    assign only_right = keys.right && !keys.left;
    assign on_ground  = (state.y == volley_pkg::PLAYER_Y_MAX);

    // walking, no move into a wall
    always_comb begin
        if (only_left && state.x > x_min) begin
            next_vx = -volley_pkg::WALK_SPEED;
        end else if (only_right && state.x < x_max) begin
            next_vx = volley_pkg::WALK_SPEED;
        end else begin
            next_vx = '0;
        end
    end

    // jump takes off only from the ground
    always_comb begin
        if (keys.jump && on_ground) begin
            next_vy = -volley_pkg::JUMP_SPEED;
        end else if (on_ground) begin
            next_vy = '0;
        end else if (vy < volley_pkg::PLAYER_MAX_FALL) begin
            next_vy = vy + volley_pkg::PLAYER_GRAVITY;
        end else begin
            next_vy = vy;                    // terminal fall speed
        end
    end

    // position moves by the velocity held before the edge
    always_comb begin
        sum_x = state.x + vx;
        sum_y = state.y + vy;

        if (sum_x < x_min) begin
            next_x = x_min;
        end else if (sum_x > x_max) begin
            next_x = x_max;
        end else begin
            next_x = volley_pkg::coord_t'(sum_x);
        end

        if (sum_y < volley_pkg::PLAYER_Y_MIN) begin
            next_y = volley_pkg::PLAYER_Y_MIN;
        end else if (sum_y > volley_pkg::PLAYER_Y_MAX) begin
            next_y = volley_pkg::PLAYER_Y_MAX;
        end else begin
            next_y = volley_pkg::coord_t'(sum_y);
        end
    end

    always_ff @(posedge fps30 or posedge rst) begin
        if (rst) begin
            vx      <= '0;
            vy      <= '0;
            state.x <= start_x;
            state.y <= volley_pkg::START_Y;
        end else if (!play) begin
            vx      <= '0;                   // back to the start spot
            vy      <= '0;
            state.x <= start_x;
            state.y <= volley_pkg::START_Y;
        end else begin
            vx      <= next_vx;
            vy      <= next_vy;
            state.x <= next_x;
            state.y <= next_y;
        end
    end

    position_in_bounds: assert property (
        @(posedge fps30) disable iff (rst)
        state.x >= x_min && state.x <= x_max &&
        state.y >= volley_pkg::PLAYER_Y_MIN && state.y <= volley_pkg::PLAYER_Y_MAX
    );

endmodule

`default_nettype wire

//--- design/volley_pkg.sv
`default_nettype none

package volley_pkg;

    typedef logic signed [10:0] coord_t;    // screen pixels
    typedef logic signed [9:0]  vel_t;

    typedef struct packed {
        logic jump;
        logic left;
        logic right;
    } player_keys_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } player_state_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } ball_state_t;

    // players, velocities in px per frame
    localparam coord_t PLAYER_Y_MIN   = 11'sd50;
    localparam coord_t PLAYER_Y_MAX   = 11'sd390;    // player ground
    localparam coord_t A_X_MIN        = 11'sd48;
    localparam coord_t A_X_MAX        = 11'sd250;
    localparam coord_t B_X_MIN        = 11'sd370;
    localparam coord_t B_X_MAX        = 11'sd582;
    localparam coord_t A_START_X      = 11'sd150;
    localparam coord_t B_START_X      = 11'sd480;
    localparam coord_t START_Y        = 11'sd390;
    localparam vel_t   WALK_SPEED     = 10'sd4;
    localparam vel_t   JUMP_SPEED     = 10'sd30;     // magnitude, applied upward
    localparam vel_t   PLAYER_GRAVITY = 10'sd2;
    localparam vel_t   PLAYER_MAX_FALL = 10'sd30;

    // ball, velocities in tenths of a px per frame
    localparam coord_t BALL_X_MIN     = 11'sd38;
    localparam coord_t BALL_X_MAX     = 11'sd592;
    localparam coord_t BALL_Y_MIN     = 11'sd38;     // ceiling
    localparam coord_t BALL_Y_MAX     = 11'sd400;    // ball ground
    localparam coord_t NET_LEFT       = 11'sd285;
    localparam coord_t NET_RIGHT      = 11'sd335;
    localparam coord_t NET_TOP        = 11'sd270;
    localparam coord_t MIDCOURT       = 11'sd320;
    localparam coord_t SERVE_A_X      = 11'sd160;
    localparam coord_t SERVE_B_X      = 11'sd480;
    localparam coord_t SERVE_Y        = 11'sd60;
    localparam vel_t   BALL_GRAVITY   = 10'sd5;
    localparam vel_t   BALL_MAX_FALL  = 10'sd150;
    localparam vel_t   DRAG           = 10'sd2;
    localparam vel_t   DRAG_LIMIT     = 10'sd40;
    localparam vel_t   HIT_VX         = 10'sd50;
    localparam vel_t   HIT_VY         = 10'sd100;    // magnitude, applied upward
    localparam coord_t HIT_RANGE_X    = 11'sd30;
    localparam coord_t HIT_RANGE_Y    = 11'sd40;

    // side that let the ball drop
    localparam logic [1:0] GROUND_NONE  = 2'd0;
    localparam logic [1:0] GROUND_LEFT  = 2'd1;
    localparam logic [1:0] GROUND_RIGHT = 2'd2;

endpackage

`default_nettype wire
